// ==== flist.f ====
source/mipsPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/hazardUnit.sv
source/aluUnit.sv
source/memAlign.sv
source/pipeDatapath.sv
verif/pipeDatapath_properties.sv
verif/pipeDatapathTb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pipeDatapathTb \
	-f flist.f -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input  mipsPkg::word_t  srcA,
	input  mipsPkg::word_t  srcB,
	input  logic [4:0]      shamt,
	input  mipsPkg::aluOp_t aluOp,
	output mipsPkg::word_t  result
);
	import mipsPkg::*;

	logic lessSigned;
	logic lessUnsigned;

	// set-less-than compares
	assign lessSigned   = $signed(srcA) < $signed(srcB);
	assign lessUnsigned = srcA < srcB;

	always_comb begin
		case (aluOp)
			// add and sub wrap, no overflow trap
			ALU_ADD:  result = srcA + srcB;
			ALU_SUB:  result = srcA - srcB;
			ALU_AND:  result = srcA & srcB;
			ALU_OR:   result = srcA | srcB;
			ALU_XOR:  result = srcA ^ srcB;
			ALU_NOR:  result = ~(srcA | srcB);
			ALU_SLT:  result = {31'd0, lessSigned};
			ALU_SLTU: result = {31'd0, lessUnsigned};
			// shifts act on rt by the shamt field
			ALU_SLL:  result = srcB << shamt;
			ALU_SRL:  result = srcB >> shamt;
			ALU_SRA:  result = $signed(srcB) >>> shamt;
			// immediate into the upper half-word
			ALU_LUI:  result = {srcB[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  mipsPkg::regAddr_t rsD,
	input  mipsPkg::regAddr_t rtD,
	input  mipsPkg::regAddr_t rsE,
	input  mipsPkg::regAddr_t rtE,
	input  mipsPkg::regAddr_t destE,
	input  mipsPkg::regAddr_t destM,
	input  mipsPkg::regAddr_t destW,
	input  logic              regWriteE,
	input  logic              memReadE,
	input  logic              regWriteM,
	input  logic              regWriteW,
	output logic [1:0]        forwardA,
	output logic [1:0]        forwardB,
	output logic              stallFD,
	output logic              flushE
);
	import mipsPkg::*;

	logic loadUse;

	// regWrite is never set for r0, so a match never forwards zero reg
	function automatic logic [1:0] forwardSel(input regAddr_t src);
		if (regWriteM && (destM == src))
			return FWD_MEM;
		if (regWriteW && (destW == src))
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		forwardA = forwardSel(rsE);
		forwardB = forwardSel(rtE);
	end

	// ==========================================================
	// load-use stall
	// ==========================================================
	// load data only exists after mem, so the consumer waits one cycle
	assign loadUse = memReadE && regWriteE && ((destE == rsD) || (destE == rtD));

	// hold fetch and decode, bubble into execute
	assign stallFD = loadUse;
	assign flushE  = loadUse;

endmodule

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  mipsPkg::word_t     instr,
	output mipsPkg::regAddr_t  rs,
	output mipsPkg::regAddr_t  rt,
	output mipsPkg::regAddr_t  destReg,
	output mipsPkg::word_t     imm,
	output logic [4:0]         shamt,
	output mipsPkg::aluOp_t    aluOp,
	output logic               aluSrcImm,
	output logic               regWrite,
	output logic               memRead,
	output logic               memWrite,
	output logic               loadSigned,
	output mipsPkg::memWidth_t memWidth
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic       zeroExt;
	logic       writes;

	// instruction fields
	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign shamt  = instr[10:6];

	// rd for r-type, rt otherwise
	assign destReg   = (opcode == OP_RTYPE) ? instr[15:11] : rt;
	assign aluSrcImm = (opcode != OP_RTYPE);

	// logical immediates are zero extended
	assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
	assign imm = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	// loads and stores share the low opcode bits for width
	assign memWidth = (opcode[1:0] == 2'b00) ? WIDTH_BYTE :
		(opcode[1:0] == 2'b01) ? WIDTH_HALF : WIDTH_WORD;
	// lbu and lhu have opcode bit 2 set
	assign loadSigned = ~opcode[2];

	always_comb begin
		aluOp    = ALU_ADD;
		writes   = 1'b1;
		memRead  = 1'b0;
		memWrite = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FUNCT_ADDU: aluOp = ALU_ADD;
					FUNCT_SUBU: aluOp = ALU_SUB;
					FUNCT_AND:  aluOp = ALU_AND;
					FUNCT_OR:   aluOp = ALU_OR;
					FUNCT_XOR:  aluOp = ALU_XOR;
					FUNCT_NOR:  aluOp = ALU_NOR;
					FUNCT_SLT:  aluOp = ALU_SLT;
					FUNCT_SLTU: aluOp = ALU_SLTU;
					FUNCT_SLL:  aluOp = ALU_SLL;
					FUNCT_SRL:  aluOp = ALU_SRL;
					FUNCT_SRA:  aluOp = ALU_SRA;
					// unknown function code retires as a nop
					default:    writes = 1'b0;
				endcase
			end
			OP_ADDIU: aluOp = ALU_ADD;
			OP_SLTI:  aluOp = ALU_SLT;
			OP_ANDI:  aluOp = ALU_AND;
			OP_ORI:   aluOp = ALU_OR;
			OP_XORI:  aluOp = ALU_XOR;
			OP_LUI:   aluOp = ALU_LUI;
			// address is base plus offset
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: memRead = 1'b1;
			OP_SB, OP_SH, OP_SW: begin
				memWrite = 1'b1;
				writes   = 1'b0;
			end
			default: writes = 1'b0;
		endcase
	end

	// writes to r0 are dropped here so no stage ever sees them
	assign regWrite = writes && (destReg != 5'd0);

endmodule

`default_nettype wire

// ==== source/memAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAlign (
	input  mipsPkg::word_t     storeData,
	input  mipsPkg::word_t     storeAddr,
	input  logic               storeEn,
	input  mipsPkg::memWidth_t storeWidth,
	output mipsPkg::byteEn_t   byteEnable,
	output mipsPkg::word_t     storeWord,
	input  mipsPkg::word_t     loadWord,
	input  logic [1:0]         loadAddrLow,
	input  mipsPkg::memWidth_t loadWidth,
	input  logic               loadSigned,
	output mipsPkg::word_t     loadResult
);
	import mipsPkg::*;

	logic [7:0]  loadByte;
	logic [15:0] loadHalf;

	// ==========================================================
	// store side, memory stage
	// ==========================================================
	always_comb begin
		storeWord  = storeData;
		byteEnable = 4'b1111;
		case (storeWidth)
			WIDTH_BYTE: begin
				// byte copied to all lanes, one lane enabled
				storeWord  = {4{storeData[7:0]}};
				byteEnable = 4'b0001 << storeAddr[1:0];
			end
			WIDTH_HALF: begin
				storeWord  = {2{storeData[15:0]}};
				byteEnable = storeAddr[1] ? 4'b1100 : 4'b0011;
			end
			default: byteEnable = 4'b1111;
		endcase
		// non-stores never write
		if (!storeEn)
			byteEnable = '0;
	end

	// ==========================================================
	// load side, writeback stage
	// ==========================================================
	// pick the addressed lane
	assign loadByte = loadWord[{loadAddrLow, 3'b000} +: 8];
	assign loadHalf = loadAddrLow[1] ? loadWord[31:16] : loadWord[15:0];

	always_comb begin
		case (loadWidth)
			WIDTH_BYTE: loadResult = {{24{loadSigned & loadByte[7]}}, loadByte};
			WIDTH_HALF: loadResult = {{16{loadSigned & loadHalf[15]}}, loadHalf};
			default:    loadResult = loadWord;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	// ==========================================================
	// datapath widths
	// ==========================================================
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	// one bit per byte lane, bit 0 is the lowest address
	typedef logic [3:0]  byteEn_t;
	typedef logic [3:0]  aluOp_t;
	typedef logic [1:0]  memWidth_t;

	// fetch address out of reset
	localparam word_t RESET_PC = 32'h0000_0000;

	// alu operations
	localparam aluOp_t ALU_ADD  = 4'd0;
	localparam aluOp_t ALU_SUB  = 4'd1;
	localparam aluOp_t ALU_AND  = 4'd2;
	localparam aluOp_t ALU_OR   = 4'd3;
	localparam aluOp_t ALU_XOR  = 4'd4;
	localparam aluOp_t ALU_NOR  = 4'd5;
	localparam aluOp_t ALU_SLT  = 4'd6;
	localparam aluOp_t ALU_SLTU = 4'd7;
	localparam aluOp_t ALU_SLL  = 4'd8;
	localparam aluOp_t ALU_SRL  = 4'd9;
	localparam aluOp_t ALU_SRA  = 4'd10;
	localparam aluOp_t ALU_LUI  = 4'd11;

	// access width, same order as the opcode low bits
	localparam memWidth_t WIDTH_BYTE = 2'd0;
	localparam memWidth_t WIDTH_HALF = 2'd1;
	localparam memWidth_t WIDTH_WORD = 2'd2;

	// ==========================================================
	// opcodes and function codes
	// ==========================================================
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LB    = 6'h20;
	localparam logic [5:0] OP_LH    = 6'h21;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_LBU   = 6'h24;
	localparam logic [5:0] OP_LHU   = 6'h25;
	localparam logic [5:0] OP_SB    = 6'h28;
	localparam logic [5:0] OP_SH    = 6'h29;
	localparam logic [5:0] OP_SW    = 6'h2b;

	localparam logic [5:0] FUNCT_SLL  = 6'h00;
	localparam logic [5:0] FUNCT_SRL  = 6'h02;
	localparam logic [5:0] FUNCT_SRA  = 6'h03;
	localparam logic [5:0] FUNCT_ADDU = 6'h21;
	localparam logic [5:0] FUNCT_SUBU = 6'h23;
	localparam logic [5:0] FUNCT_AND  = 6'h24;
	localparam logic [5:0] FUNCT_OR   = 6'h25;
	localparam logic [5:0] FUNCT_XOR  = 6'h26;
	localparam logic [5:0] FUNCT_NOR  = 6'h27;
	localparam logic [5:0] FUNCT_SLT  = 6'h2a;
	localparam logic [5:0] FUNCT_SLTU = 6'h2b;

	// execute operand source, mem stage holds the younger value
	localparam logic [1:0] FWD_NONE = 2'b00;
	localparam logic [1:0] FWD_WB   = 2'b01;
	localparam logic [1:0] FWD_MEM  = 2'b10;

endpackage

`default_nettype wire

// ==== source/pipeDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeDatapath (
	input  logic              clk,
	input  logic              reset,
	output mipsPkg::word_t    pcF,
	input  mipsPkg::word_t    instrF,
	output mipsPkg::word_t    dataAddr,
	output mipsPkg::word_t    writeData,
	output mipsPkg::byteEn_t  byteEnable,
	input  mipsPkg::word_t    readData,
	output mipsPkg::word_t    pcW,
	output logic              regWriteW,
	output mipsPkg::regAddr_t writeRegW,
	output mipsPkg::word_t    resultW
);
	import mipsPkg::*;

	// hazard control
	logic [1:0] forwardA, forwardB;
	logic       stallFD, flushE;

	// decode stage
	word_t      instrD, pcD, immD, readDataAD, readDataBD;
	regAddr_t   rsD, rtD, destD;
	logic [4:0] shamtD;
	aluOp_t     aluOpD;
	memWidth_t  memWidthD;
	logic       aluSrcImmD, regWriteD, memReadD, memWriteD, loadSignedD;

	// execute stage
	word_t      pcE, srcAE, srcBE, immE, srcAFwdE, srcBFwdE, aluResultE;
	regAddr_t   rsE, rtE, destE;
	logic [4:0] shamtE;
	aluOp_t     aluOpE;
	memWidth_t  memWidthE;
	logic       aluSrcImmE, regWriteE, memReadE, memWriteE, loadSignedE;

	// memory stage
	word_t      pcM, aluResultM, storeDataM;
	regAddr_t   destM;
	memWidth_t  memWidthM;
	logic       regWriteM, memReadM, memWriteM, loadSignedM;

	// writeback stage
	word_t      aluResultW, readDataW, loadResultW;
	memWidth_t  memWidthW;
	logic       memReadW, loadSignedW;

	// ==========================================================
	// fetch
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset)
			pcF <= RESET_PC;
		else if (!stallFD)
			pcF <= pcF + 32'd4;
	end

	// ==========================================================
	// pipeline registers
	// ==========================================================
	// control, cleared to a bubble by reset
	always_ff @(posedge clk) begin
		if (reset) begin
			instrD    <= '0;
			regWriteE <= 1'b0;
			memReadE  <= 1'b0;
			memWriteE <= 1'b0;
			regWriteM <= 1'b0;
			memReadM  <= 1'b0;
			memWriteM <= 1'b0;
			regWriteW <= 1'b0;
			memReadW  <= 1'b0;
		end else begin
			// stall holds decode
			if (!stallFD)
				instrD <= instrF;
			// flush drops a bubble into execute
			regWriteE <= regWriteD & ~flushE;
			memReadE  <= memReadD & ~flushE;
			memWriteE <= memWriteD & ~flushE;
			regWriteM <= regWriteE;
			memReadM  <= memReadE;
			memWriteM <= memWriteE;
			regWriteW <= regWriteM;
			memReadW  <= memReadM;
		end
	end

	// payload follows its control
	always_ff @(posedge clk) begin
		if (!stallFD)
			pcD <= pcF;
		pcE         <= pcD;
		srcAE       <= readDataAD;
		srcBE       <= readDataBD;
		immE        <= immD;
		shamtE      <= shamtD;
		rsE         <= rsD;
		rtE         <= rtD;
		destE       <= destD;
		aluOpE      <= aluOpD;
		aluSrcImmE  <= aluSrcImmD;
		memWidthE   <= memWidthD;
		loadSignedE <= loadSignedD;
		pcM         <= pcE;
		aluResultM  <= aluResultE;
		storeDataM  <= srcBFwdE;
		destM       <= destE;
		memWidthM   <= memWidthE;
		loadSignedM <= loadSignedE;
		pcW         <= pcM;
		aluResultW  <= aluResultM;
		readDataW   <= readData;
		writeRegW   <= destM;
		memWidthW   <= memWidthM;
		loadSignedW <= loadSignedM;
	end

	// ==========================================================
	// decode
	// ==========================================================
	instrDecoder u_decoder (
		.instr(instrD), .rs(rsD), .rt(rtD), .destReg(destD), .imm(immD),
		.shamt(shamtD), .aluOp(aluOpD), .aluSrcImm(aluSrcImmD), .regWrite(regWriteD),
		.memRead(memReadD), .memWrite(memWriteD), .loadSigned(loadSignedD),
		.memWidth(memWidthD)
	);

	// written from writeback, bypass covers distance three
	regFile u_regFile (
		.clk(clk), .reset(reset), .writeEn(regWriteW), .writeAddr(writeRegW),
		.writeData(resultW), .readAddrA(rsD), .readAddrB(rtD),
		.readDataA(readDataAD), .readDataB(readDataBD)
	);

	hazardUnit u_hazard (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .destE(destE), .destM(destM),
		.destW(writeRegW), .regWriteE(regWriteE), .memReadE(memReadE),
		.regWriteM(regWriteM), .regWriteW(regWriteW), .forwardA(forwardA),
		.forwardB(forwardB), .stallFD(stallFD), .flushE(flushE)
	);

	// ==========================================================
	// execute
	// ==========================================================
	// a load never sits in mem when its consumer is in execute
	function automatic word_t forwardMux(input logic [1:0] sel, input word_t regValue,
		input word_t memValue, input word_t wbValue);
		case (sel)
			FWD_MEM: return memValue;
			FWD_WB:  return wbValue;
			default: return regValue;
		endcase
	endfunction

	assign srcAFwdE = forwardMux(forwardA, srcAE, aluResultM, resultW);
	assign srcBFwdE = forwardMux(forwardB, srcBE, aluResultM, resultW);

	aluUnit u_alu (
		.srcA(srcAFwdE), .srcB(aluSrcImmE ? immE : srcBFwdE), .shamt(shamtE),
		.aluOp(aluOpE), .result(aluResultE)
	);

	// ==========================================================
	// memory and writeback
	// ==========================================================
	assign dataAddr = aluResultM;

	// store side in mem, load side in wb from registered data
	memAlign u_memAlign (
		.storeData(storeDataM), .storeAddr(aluResultM), .storeEn(memWriteM),
		.storeWidth(memWidthM), .byteEnable(byteEnable), .storeWord(writeData),
		.loadWord(readDataW), .loadAddrLow(aluResultW[1:0]), .loadWidth(memWidthW),
		.loadSigned(loadSignedW), .loadResult(loadResultW)
	);

	// aligned load data or alu result
	assign resultW = memReadW ? loadResultW : aluResultW;

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic              clk,
	input  logic              reset,
	input  logic              writeEn,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::word_t    writeData,
	input  mipsPkg::regAddr_t readAddrA,
	input  mipsPkg::regAddr_t readAddrB,
	output mipsPkg::word_t    readDataA,
	output mipsPkg::word_t    readDataB
);
	import mipsPkg::*;

	// r0 has no storage
	word_t regs [31:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != 5'd0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// r0 reads zero, same-cycle write is bypassed
	function automatic word_t readPort(input regAddr_t addr);
		if (addr == 5'd0)
			return '0;
		if (writeEn && (writeAddr == addr))
			return writeData;
		return regs[addr];
	endfunction

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

`default_nettype wire

// ==== verif/pipeDatapathTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeDatapathTb;
	import mipsPkg::*;

	localparam int PROG_LEN   = 128;
	localparam int DMEM_WORDS = 64;
	localparam int TIMEOUT    = 2000;

	// one expected register write
	typedef struct packed {
		word_t    pc;
		regAddr_t dest;
		word_t    value;
	} retire_t;

	logic     clk;
	logic     reset;
	word_t    instrF;
	word_t    readData;
	word_t    pcF;
	word_t    dataAddr;
	word_t    writeData;
	byteEn_t  byteEnable;
	word_t    pcW;
	logic     regWriteW;
	regAddr_t writeRegW;
	word_t    resultW;

	word_t   prog [PROG_LEN];
	word_t   dmem [DMEM_WORDS];
	word_t   refRegs [32];
	word_t   refMem [DMEM_WORDS];
	retire_t expected [$];
	int      progCount;
	int      errors;

	pipeDatapath u_dut (
		.clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF), .dataAddr(dataAddr),
		.writeData(writeData), .byteEnable(byteEnable), .readData(readData), .pcW(pcW),
		.regWriteW(regWriteW), .writeRegW(writeRegW), .resultW(resultW)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==========================================================
	// instruction rom and data memory
	// ==========================================================
	// nop past the end of the program
	assign instrF = ((pcF >> 2) < word_t'(progCount)) ? prog[pcF[8:2]] : '0;
	assign readData = dmem[dataAddr[7:2]];

	// scrambled start image per word index
	function automatic word_t memFill(input int idx);
		return (word_t'(idx) * 32'h9e37_79b9) ^ 32'hc3a5_5a3c ^ (word_t'(idx) << 24);
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= memFill(i);
		end else begin
			// only enabled lanes change
			for (int b = 0; b < 4; b++) begin
				if (byteEnable[b])
					dmem[dataAddr[7:2]][8 * b +: 8] <= writeData[8 * b +: 8];
			end
		end
	end

	// ==========================================================
	// isa reference model
	// ==========================================================
	function automatic void refStep(input word_t instr, output logic wr,
		output regAddr_t dest, output word_t value);
		logic [5:0] op;
		word_t      a;
		word_t      b;
		word_t      sImm;
		word_t      zImm;
		word_t      word;
		int         idx;
		int         lane;
		op    = instr[31:26];
		a     = refRegs[instr[25:21]];
		b     = refRegs[instr[20:16]];
		sImm  = {{16{instr[15]}}, instr[15:0]};
		zImm  = {16'h0000, instr[15:0]};
		idx   = int'(((a + sImm) >> 2) & 32'h3f);
		lane  = int'((a + sImm) & 32'h3);
		word  = refMem[idx];
		wr    = 1'b1;
		dest  = instr[20:16];
		value = '0;
		case (op)
			OP_RTYPE: begin
				dest = instr[15:11];
				case (instr[5:0])
					FUNCT_ADDU: value = a + b;
					FUNCT_SUBU: value = a - b;
					FUNCT_AND:  value = a & b;
					FUNCT_OR:   value = a | b;
					FUNCT_XOR:  value = a ^ b;
					FUNCT_NOR:  value = ~(a | b);
					FUNCT_SLT:  value = {31'd0, $signed(a) < $signed(b)};
					FUNCT_SLTU: value = {31'd0, a < b};
					FUNCT_SLL:  value = b << instr[10:6];
					FUNCT_SRL:  value = b >> instr[10:6];
					FUNCT_SRA:  value = $signed(b) >>> instr[10:6];
					default:    wr = 1'b0;
				endcase
			end
			OP_ADDIU: value = a + sImm;
			OP_SLTI:  value = {31'd0, $signed(a) < $signed(sImm)};
			OP_ANDI:  value = a & zImm;
			OP_ORI:   value = a | zImm;
			OP_XORI:  value = a ^ zImm;
			OP_LUI:   value = {instr[15:0], 16'h0000};
			// lane picked by the low address bits
			OP_LW:    value = word;
			OP_LB:    value = {{24{word[8 * lane + 7]}}, word[8 * lane +: 8]};
			OP_LBU:   value = {24'd0, word[8 * lane +: 8]};
			OP_LH:    value = {{16{word[16 * (lane / 2) + 15]}}, word[16 * (lane / 2) +: 16]};
			OP_LHU:   value = {16'd0, word[16 * (lane / 2) +: 16]};
			OP_SB: begin
				refMem[idx][8 * lane +: 8] = b[7:0];
				wr = 1'b0;
			end
			OP_SH: begin
				refMem[idx][16 * (lane / 2) +: 16] = b[15:0];
				wr = 1'b0;
			end
			OP_SW: begin
				refMem[idx] = b;
				wr = 1'b0;
			end
			default: wr = 1'b0;
		endcase
		// r0 is hardwired
		if (dest == 5'd0)
			wr = 1'b0;
		if (wr)
			refRegs[dest] = value;
	endfunction

	// ==========================================================
	// program assembly
	// ==========================================================
	function automatic word_t rType(input logic [5:0] funct, input regAddr_t rd,
		input regAddr_t rs, input regAddr_t rt, input logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rd, sh, funct};
	endfunction

	function automatic word_t iType(input logic [5:0] op, input regAddr_t rt,
		input regAddr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// append to rom and queue any write the model predicts
	task automatic emit(input word_t instr);
		logic     wr;
		regAddr_t dest;
		word_t    value;
		retire_t  entry;
		prog[progCount] = instr;
		refStep(instr, wr, dest, value);
		entry.pc    = word_t'(4 * progCount);
		entry.dest  = dest;
		entry.value = value;
		if (wr)
			expected.push_back(entry);
		progCount++;
	endtask

	// r1 holds the data base and is never a destination here
	task automatic emitRandomAlu(input int count);
		regAddr_t   rd;
		regAddr_t   rs;
		regAddr_t   rt;
		logic [15:0] imm;
		logic [4:0]  sh;
		for (int n = 0; n < count; n++) begin
			rd  = regAddr_t'($urandom_range(15, 2));
			rs  = regAddr_t'($urandom_range(15, 0));
			rt  = regAddr_t'($urandom_range(15, 0));
			imm = 16'($urandom);
			sh  = 5'($urandom);
			case ($urandom_range(16, 0))
				0:  emit(rType(FUNCT_ADDU, rd, rs, rt, 5'd0));
				1:  emit(rType(FUNCT_SUBU, rd, rs, rt, 5'd0));
				2:  emit(rType(FUNCT_AND, rd, rs, rt, 5'd0));
				3:  emit(rType(FUNCT_OR, rd, rs, rt, 5'd0));
				4:  emit(rType(FUNCT_XOR, rd, rs, rt, 5'd0));
				5:  emit(rType(FUNCT_NOR, rd, rs, rt, 5'd0));
				6:  emit(rType(FUNCT_SLT, rd, rs, rt, 5'd0));
				7:  emit(rType(FUNCT_SLTU, rd, rs, rt, 5'd0));
				8:  emit(rType(FUNCT_SLL, rd, 5'd0, rt, sh));
				9:  emit(rType(FUNCT_SRL, rd, 5'd0, rt, sh));
				10: emit(rType(FUNCT_SRA, rd, 5'd0, rt, sh));
				11: emit(iType(OP_ADDIU, rd, rs, imm));
				12: emit(iType(OP_SLTI, rd, rs, imm));
				13: emit(iType(OP_ANDI, rd, rs, imm));
				14: emit(iType(OP_ORI, rd, rs, imm));
				15: emit(iType(OP_XORI, rd, rs, imm));
				default: emit(iType(OP_LUI, rd, 5'd0, imm));
			endcase
		end
	endtask

	task automatic buildProgram();
		// base pointer and seed values with no loads early on
		emit(iType(OP_ORI, 5'd1, 5'd0, 16'h0080));
		emit(iType(OP_LUI, 5'd2, 5'd0, 16'h8765));
		emit(iType(OP_ORI, 5'd2, 5'd2, 16'h4321));
		emit(iType(OP_ADDIU, 5'd3, 5'd0, 16'hfff0));
		emitRandomAlu(30);
		// r4 consumed at distance one, two and three
		emit(rType(FUNCT_ADDU, 5'd4, 5'd2, 5'd3, 5'd0));
		emit(rType(FUNCT_SUBU, 5'd5, 5'd4, 5'd2, 5'd0));
		emit(rType(FUNCT_XOR, 5'd6, 5'd3, 5'd4, 5'd0));
		emit(rType(FUNCT_SRA, 5'd7, 5'd0, 5'd4, 5'd3));
		emit(rType(FUNCT_OR, 5'd8, 5'd5, 5'd7, 5'd0));
		// stores at every lane offset
		emit(iType(OP_SW, 5'd2, 5'd1, 16'd0));
		for (int k = 0; k < 4; k++)
			emit(iType(OP_SB, regAddr_t'(4 + k), 5'd1, 16'(4 + k)));
		emit(iType(OP_SH, 5'd5, 5'd1, 16'd8));
		emit(iType(OP_SH, 5'd6, 5'd1, 16'd10));
		emit(iType(OP_SW, 5'd3, 5'd1, 16'd12));
		// loads of every width and lane with some from untouched words
		for (int k = 0; k < 4; k++) begin
			emit(iType(OP_LB, regAddr_t'(8 + k), 5'd1, 16'(4 + k)));
			emit(iType(OP_LBU, regAddr_t'(12 + k), 5'd1, 16'(24 + k)));
		end
		for (int k = 0; k < 2; k++) begin
			emit(iType(OP_LH, regAddr_t'(8 + k), 5'd1, 16'(8 + 2 * k)));
			emit(iType(OP_LHU, regAddr_t'(12 + k), 5'd1, 16'(28 + 2 * k)));
		end
		// load-use pairs on rs, on store data and on an immediate op
		emit(iType(OP_LW, 5'd9, 5'd1, 16'd0));
		emit(rType(FUNCT_ADDU, 5'd10, 5'd9, 5'd9, 5'd0));
		emit(iType(OP_LH, 5'd11, 5'd1, 16'd10));
		emit(iType(OP_SW, 5'd11, 5'd1, 16'd20));
		emit(iType(OP_LW, 5'd12, 5'd1, 16'd20));
		emit(iType(OP_ADDIU, 5'd13, 5'd12, 16'h0001));
		emit(iType(OP_LW, 5'd14, 5'd1, 16'd12));
		// r0 targets and unknown encodings before r0 is read back
		emit(iType(OP_ADDIU, 5'd0, 5'd2, 16'h0011));
		emit(rType(FUNCT_ADDU, 5'd0, 5'd2, 5'd3, 5'd0));
		emit(iType(OP_LW, 5'd0, 5'd1, 16'd0));
		emit(32'hfc00_0000);
		emit(rType(6'h3f, 5'd9, 5'd2, 5'd3, 5'd0));
		emit(rType(FUNCT_OR, 5'd15, 5'd0, 5'd0, 5'd0));
		emit(rType(FUNCT_ADDU, 5'd14, 5'd0, 5'd2, 5'd0));
	endtask

	// ==========================================================
	// checking
	// ==========================================================
	task automatic reportMismatch(input string name, input word_t expVal, input word_t gotVal);
		errors++;
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
	endtask

	// retired writes against the queue in program order
	always @(negedge clk) begin
		retire_t head;
		if (!reset && regWriteW) begin
			assert (expected.size() != 0) else begin
				errors++;
				$display("writeback of r%0d at %0t was not expected", writeRegW, $time);
			end
			if (expected.size() != 0) begin
				head = expected.pop_front();
				assert (pcW == head.pc) else reportMismatch("pcW", head.pc, pcW);
				assert (writeRegW == head.dest)
					else reportMismatch("writeRegW", word_t'(head.dest), word_t'(writeRegW));
				assert (resultW == head.value) else reportMismatch("resultW", head.value, resultW);
			end
		end
	end

	initial begin
		int waitCycles;
		errors    = 0;
		progCount = 0;
		reset     = 1'b1;
		void'($urandom(32'hf791));
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			refMem[i] = memFill(i);
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = '0;
		buildProgram();

		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// fetch counts up from zero while nothing retires or stores
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			assert (pcF == word_t'(4 * c)) else reportMismatch("pcF", word_t'(4 * c), pcF);
			if (c < 4) begin
				assert (!regWriteW) else begin
					errors++;
					$display("register write at %0t before the first instruction retired", $time);
				end
				assert (byteEnable == '0)
					else reportMismatch("byteEnable", 32'd0, word_t'(byteEnable));
			end
		end

		// all writes retired and fetch well past the program
		waitCycles = 0;
		while ((expected.size() != 0 || pcF < word_t'(4 * progCount + 32))
			&& waitCycles < TIMEOUT) begin
			@(negedge clk);
			waitCycles++;
		end
		if (waitCycles >= TIMEOUT) begin
			errors++;
			$display("timed out with %0d register writes outstanding", expected.size());
		end

		// memory image against the model
		for (int i = 0; i < DMEM_WORDS; i++)
			assert (dmem[i] == refMem[i])
				else reportMismatch($sformatf("dmem[%0d]", i), refMem[i], dmem[i]);

		$display("run complete with %0d errors", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/pipeDatapath_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeDatapathProperties (
	input logic              clk,
	input logic              reset,
	input mipsPkg::byteEn_t  byteEnable,
	input logic              regWriteW,
	input mipsPkg::regAddr_t writeRegW,
	input logic              stallFD
);

	// ==========================================================
	// store lanes and writeback
	// ==========================================================
	// none, one byte, an aligned half or the full word
	legalLanes: assert property (@(posedge clk) disable iff (reset)
		$onehot0(byteEnable) || (byteEnable == 4'b0011) || (byteEnable == 4'b1100)
		|| (byteEnable == 4'b1111))
		else $error("byteEnable %b is not a legal lane pattern", byteEnable);

	// r0 is never reported
	noZeroWrite: assert property (@(posedge clk) disable iff (reset)
		regWriteW |-> (writeRegW != 5'd0))
		else $error("register write reported for r0");

	// load-use costs one cycle only
	singleStall: assert property (@(posedge clk) disable iff (reset)
		stallFD |=> !stallFD)
		else $error("stall held for two cycles");

	// bubbles everywhere out of reset
	quietAfterReset: assert property (@(posedge clk)
		reset |=> (!regWriteW && (byteEnable == 4'b0000)))
		else $error("write activity in the cycle after reset");

endmodule

bind pipeDatapath pipeDatapathProperties u_props (
	.clk(clk), .reset(reset), .byteEnable(byteEnable), .regWriteW(regWriteW),
	.writeRegW(writeRegW), .stallFD(stallFD)
);

`default_nettype wire
